//--- mem_pkg.sv
/*
 * Shared types and constants for the RV32-style load/store subsystem.
 * Imported by the execution unit, memory handler, RAM and peripheral.
 */
package mem_pkg;

    // widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [8:0]  ram_idx_t;

    // handler sequencing
    typedef enum logic [2:0] {
        INC,
        FETCH,
        FWAIT,
        LORS,
        LWAIT,
        REGOP
    } hstate_t;

    // handler to RAM, read and write are levels
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } mem_req_t;

    // execution unit to handler, decoded from the held instruction
    typedef struct packed {
        logic    read;
        logic    write;
        funct3_t funct3;
        word_t   addr;
        word_t   wdata;
    } mem_op_t;

    // register file write port, also observed at the top
    typedef struct packed {
        logic     we;
        reg_idx_t idx;
        word_t    data;
    } reg_wr_t;

    // address map
    localparam word_t I2C_ADDRESS = 32'd923923;
    localparam word_t RAM_BYTES   = 32'd2048;
    localparam int    RAM_WORDS   = 512;

    // peripheral busy time after a read starts
    localparam int I2C_BUSY_CYCLES = 3;
    localparam int I2C_CNT_W       = $clog2(I2C_BUSY_CYCLES + 1);

    // RV32 major opcodes
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_ADDI  = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;

endpackage

//--- exec_unit.sv
/*
 * Execution unit: program counter, eight-entry register file and decode.
 * Turns the held instruction into a load/store op for the memory handler
 * and retires ADDI/LUI on inst_valid, loads on load_valid.
 */
`timescale 1ns/1ps

module exec_unit (
    input  logic              clk,
    input  logic              nrst,
    input  mem_pkg::word_t    instruction,
    input  logic              inst_valid,
    input  mem_pkg::word_t    toreg,
    input  logic              load_valid,
    input  logic              counter_on,
    output mem_pkg::word_t    pc,
    output mem_pkg::mem_op_t  op,
    output mem_pkg::reg_wr_t  reg_wr,
    output logic              halted
);
    import mem_pkg::*;

    word_t      regs [0:7];
    logic [6:0] opcode;
    funct3_t    funct3;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    word_t      rs1_val;
    word_t      rs2_val;
    logic       is_load;
    logic       is_store;
    logic       is_addi;
    logic       is_lui;
    word_t      alu_val;

    // field decode, only the low three bits of each register index are kept
    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign rd     = instruction[9:7];
    assign rs1    = instruction[17:15];
    assign rs2    = instruction[22:20];
    assign imm_i  = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s  = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_u  = {instruction[31:12], 12'b0};

    assign is_load  = (opcode == OP_LOAD);
    assign is_store = (opcode == OP_STORE);
    assign is_addi  = (opcode == OP_ADDI) && (funct3 == 3'd0);
    assign is_lui   = (opcode == OP_LUI);

    // x0 is never written, so it keeps its reset zero
    assign rs1_val = regs[rs1];
    assign rs2_val = regs[rs2];
    assign alu_val = is_lui ? imm_u : rs1_val + imm_i;

    // held instruction keeps this stable until the next fetch completes
    always_comb begin
        op.read   = !halted && is_load;
        op.write  = !halted && is_store;
        op.funct3 = funct3;
        op.addr   = rs1_val + (is_store ? imm_s : imm_i);
        op.wdata  = rs2_val;
    end

    // one write port, shared by ADDI/LUI and load write-back
    always_comb begin
        reg_wr.idx  = rd;
        reg_wr.data = load_valid ? toreg : alu_val;
        reg_wr.we   = !halted && (rd != '0) &&
                      (load_valid || (inst_valid && (is_addi || is_lui)));
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pc     <= '0;
            halted <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // pc steps while the handler samples it in FETCH
            if (counter_on && !halted) begin
                pc <= pc + 32'd4;
            end
            // all-zero instruction stops the unit for good
            if (inst_valid && (instruction == '0)) begin
                halted <= 1'b1;
            end
            if (reg_wr.we) begin
                regs[reg_wr.idx] <= reg_wr.data;
            end
        end
    end

endmodule

//--- mem_handler.sv
/*
 * Memory handler FSM: fetches each instruction, then runs its load or
 * store on the RAM bus and hands load results back for write-back.
 * INC -> FETCH -> FWAIT -> LORS -> (LWAIT -> REGOP) -> INC
 */
`timescale 1ns/1ps

module mem_handler (
    input  logic              clk,
    input  logic              nrst,
    input  mem_pkg::word_t    pc,
    input  mem_pkg::mem_op_t  op,
    input  mem_pkg::word_t    rdata,
    input  logic              gdone,
    input  logic              done,
    output mem_pkg::mem_req_t req,
    output logic [3:0]        wmask,
    output mem_pkg::word_t    instruction,
    output logic              inst_valid,
    output mem_pkg::word_t    toreg,
    output logic              load_valid,
    output logic              counter_on
);
    import mem_pkg::*;

    hstate_t state;
    hstate_t next_state;
    word_t   fetch_addr;
    word_t   store_data;
    word_t   load_data;
    logic    mem_phase;
    logic    load_ready;

    // load/store request is live in LORS and held through LWAIT
    assign mem_phase = (state == LORS) || (state == LWAIT);

    // levels fall as soon as gdone moves the state on
    always_comb begin
        req.addr  = mem_phase ? op.addr : fetch_addr;
        req.wdata = store_data;
        req.read  = (state == FWAIT) || (mem_phase && op.read);
        req.write = mem_phase && op.write;
    end

    // store shaping, sub-word data always sits in the low lanes
    always_comb begin
        case (op.funct3)
            3'd0: begin
                store_data = {24'b0, op.wdata[7:0]};
                wmask      = 4'b0001;
            end
            3'd1: begin
                store_data = {16'b0, op.wdata[15:0]};
                wmask      = 4'b0011;
            end
            default: begin
                store_data = op.wdata;
                wmask      = 4'b1111;
            end
        endcase
    end

    // load extension from bit 7 or bit 15
    always_comb begin
        case (op.funct3)
            3'd0:    load_data = {{24{rdata[7]}}, rdata[7:0]};
            3'd1:    load_data = {{16{rdata[15]}}, rdata[15:0]};
            3'd4:    load_data = {24'b0, rdata[7:0]};
            3'd5:    load_data = {16'b0, rdata[15:0]};
            default: load_data = rdata;
        endcase
    end

    // only the peripheral makes us wait for done
    assign load_ready = (op.addr != I2C_ADDRESS) || done;

    always_comb begin
        next_state = state;
        case (state)
            INC:   next_state = FETCH;
            FETCH: next_state = FWAIT;
            FWAIT: begin
                if (gdone) begin
                    next_state = LORS;
                end
            end
            LORS: begin
                // ADDI, LUI and halt retire here
                if (op.read || op.write) begin
                    next_state = LWAIT;
                end else begin
                    next_state = INC;
                end
            end
            LWAIT: begin
                if (gdone) begin
                    next_state = op.read ? REGOP : INC;
                end
            end
            REGOP: begin
                if (load_ready) begin
                    next_state = INC;
                end
            end
            default: next_state = INC;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= INC;
            counter_on  <= 1'b0;
            inst_valid  <= 1'b0;
            load_valid  <= 1'b0;
            instruction <= '0;
        end else begin
            state      <= next_state;
            // high for exactly the FETCH cycle
            counter_on <= (next_state == FETCH);
            inst_valid <= (state == FWAIT) && gdone;
            load_valid <= (state == REGOP) && load_ready;
            if ((state == FWAIT) && gdone) begin
                instruction <= rdata;
            end
        end
    end

    // fetch address and load result
    always_ff @(posedge clk) begin
        if (state == FETCH) begin
            fetch_addr <= pc;
        end
        if ((state == REGOP) && load_ready) begin
            toreg <= load_data;
        end
    end

endmodule

//--- data_ram.sv
/*
 * 2 KiB word RAM preloaded from program.hex, shared by fetch and data.
 * Each access completes with a gdone pulse two cycles after it starts;
 * the peripheral address is decoded here and its register read back.
 */
`timescale 1ns/1ps

module data_ram (
    input  logic              clk,
    input  logic              nrst,
    input  mem_pkg::mem_req_t req,
    input  logic [3:0]        wmask,
    output mem_pkg::word_t    rdata,
    output logic              gdone,
    output logic              i2c_sel,
    input  mem_pkg::word_t    i2c_rdata
);
    import mem_pkg::*;

    word_t      mem [RAM_WORDS];
    mem_req_t   s1_req;
    logic [3:0] s1_mask;
    logic       s1_valid;
    logic       start;
    logic       s1_ram;
    ram_idx_t   s1_idx;

    initial begin
        $readmemh("program.hex", mem);
    end

    assign i2c_sel = (req.addr == I2C_ADDRESS);

    // new access once the pipeline has drained, a held level is not restarted
    assign start = (req.read || req.write) && !s1_valid && !gdone;

    // low address bits ignored, word index only
    assign s1_idx = s1_req.addr[10:2];
    assign s1_ram = (s1_req.addr < RAM_BYTES);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            s1_valid <= 1'b0;
            gdone    <= 1'b0;
        end else begin
            s1_valid <= start;
            gdone    <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1_req  <= req;
            s1_mask <= wmask;
        end
        if (s1_valid) begin
            rdata <= (s1_req.addr == I2C_ADDRESS) ? i2c_rdata : mem[s1_idx];
            // byte merge into the stored word
            if (s1_req.write && s1_ram) begin
                for (int b = 0; b < 4; b++) begin
                    if (s1_mask[b]) begin
                        mem[s1_idx][b*8 +: 8] <= s1_req.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- i2c_port.sv
/*
 * I2C-like peripheral register. A write stores the data; a read raises
 * done after a fixed busy time and done holds until the next access.
 */
`timescale 1ns/1ps

module i2c_port (
    input  logic           clk,
    input  logic           nrst,
    input  logic           sel,
    input  logic           write,
    input  logic           read,
    input  mem_pkg::word_t wdata,
    output mem_pkg::word_t rdata,
    output logic           done
);
    import mem_pkg::*;

    logic [I2C_CNT_W-1:0] count;
    logic                 access;
    logic                 access_q;
    logic                 start;

    assign access = sel && (read || write);
    // levels stay high for several cycles, so act on the rise only
    assign start  = access && !access_q;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rdata    <= '0;
            count    <= '0;
            done     <= 1'b0;
            access_q <= 1'b0;
        end else begin
            access_q <= access;
            if (sel && write) begin
                rdata <= wdata;
            end
            if (start) begin
                done  <= 1'b0;
                count <= read ? I2C_CNT_W'(I2C_BUSY_CYCLES - 1) : '0;
            end else if (count != '0) begin
                count <= count - 1'b1;
                // last busy cycle
                if (count == I2C_CNT_W'(1)) begin
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- soc_top.sv
/*
 * Subsystem top: execution unit, memory handler, RAM and peripheral.
 * Register writes and the RAM bus request are brought out for checking.
 */
`timescale 1ns/1ps

module soc_top (
    input  logic              clk,
    input  logic              nrst,
    output mem_pkg::reg_wr_t  reg_wr,
    output mem_pkg::mem_req_t mem_wr,
    output logic              halted
);
    import mem_pkg::*;

    word_t      pc;
    word_t      instruction;
    word_t      toreg;
    word_t      rdata;
    word_t      i2c_rdata;
    mem_op_t    op;
    mem_req_t   req;
    logic [3:0] wmask;
    logic       inst_valid;
    logic       load_valid;
    logic       counter_on;
    logic       gdone;
    logic       done;
    logic       i2c_sel;

    // bus request as seen by the RAM
    assign mem_wr = req;

    exec_unit u_exec (
        .clk         (clk),
        .nrst        (nrst),
        .instruction (instruction),
        .inst_valid  (inst_valid),
        .toreg       (toreg),
        .load_valid  (load_valid),
        .counter_on  (counter_on),
        .pc          (pc),
        .op          (op),
        .reg_wr      (reg_wr),
        .halted      (halted)
    );

    mem_handler u_handler (
        .clk         (clk),
        .nrst        (nrst),
        .pc          (pc),
        .op          (op),
        .rdata       (rdata),
        .gdone       (gdone),
        .done        (done),
        .req         (req),
        .wmask       (wmask),
        .instruction (instruction),
        .inst_valid  (inst_valid),
        .toreg       (toreg),
        .load_valid  (load_valid),
        .counter_on  (counter_on)
    );

    data_ram u_ram (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .wmask     (wmask),
        .rdata     (rdata),
        .gdone     (gdone),
        .i2c_sel   (i2c_sel),
        .i2c_rdata (i2c_rdata)
    );

    // peripheral sees the raw bus levels, gated by the RAM's address decode
    i2c_port u_i2c (
        .clk   (clk),
        .nrst  (nrst),
        .sel   (i2c_sel),
        .write (req.write),
        .read  (req.read),
        .wdata (req.wdata),
        .rdata (i2c_rdata),
        .done  (done)
    );

endmodule

//--- tb_soc.sv
/*
 * Testbench for soc_top. An ISA model run over program.hex predicts every
 * register write and bus write in order, and a compare process checks the
 * DUT against that queue as the events appear.
 */
`timescale 1ns/1ps

module tb_soc;
    import mem_pkg::*;

    // test groups with one report line each
    localparam int N_TESTS = 6;
    localparam int T_ALU   = 0;
    localparam int T_STORE = 1;
    localparam int T_LOAD  = 2;
    localparam int T_MERGE = 3;
    localparam int T_I2C   = 4;
    localparam int T_HALT  = 5;

    // one predicted register or bus write
    typedef struct packed {
        logic       is_mem;
        logic [2:0] test;
        word_t      addr;
        word_t      data;
        logic [3:0] mask;
    } exp_event_t;

    logic     clk;
    logic     nrst;
    reg_wr_t  reg_wr;
    mem_req_t mem_wr;
    logic     halted;

    exp_event_t expected [$];
    word_t      model_mem [RAM_WORDS];
    string      test_name [N_TESTS];
    int         exp_count [N_TESTS];
    int         seen_count [N_TESTS];
    int         err_count [N_TESTS];
    int         errors;
    int         checked;
    int         reg_writes;
    int         mem_writes;
    int         model_regs;
    int         model_mems;
    int         steps;
    int         cycles;
    int         limit;
    logic       prev_write;
    logic       timed_out;

    soc_top dut (
        .clk    (clk),
        .nrst   (nrst),
        .reg_wr (reg_wr),
        .mem_wr (mem_wr),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic void push_event(input logic is_mem, input int test,
                                       input word_t addr, input word_t data,
                                       input logic [3:0] mask);
        exp_event_t ev;
        ev.is_mem = is_mem;
        ev.test   = 3'(test);
        ev.addr   = addr;
        ev.data   = data;
        ev.mask   = mask;
        expected.push_back(ev);
        exp_count[test]++;
        if (is_mem) begin
            model_mems++;
        end else begin
            model_regs++;
        end
    endfunction

    // ISA model that returns the number of instructions up to and including halt
    function automatic int build_expected();
        word_t      x [8];
        logic       stored [RAM_WORDS];
        word_t      pc;
        word_t      inst;
        word_t      ea;
        word_t      raw;
        word_t      val;
        word_t      data;
        word_t      i2c_reg;
        logic [3:0] mask;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic [2:0] rs2;
        logic       running;
        logic       wr_reg;
        int         t;
        int         n;
        for (int i = 0; i < RAM_WORDS; i++) begin
            model_mem[i] = '0;
            stored[i]    = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            x[i] = '0;
        end
        $readmemh("program.hex", model_mem);
        pc      = '0;
        i2c_reg = '0;
        n       = 0;
        running = 1'b1;
        while (running && (n < RAM_WORDS)) begin
            inst   = model_mem[pc[10:2]];
            pc     = pc + 32'd4;
            n++;
            opc    = inst[6:0];
            f3     = inst[14:12];
            rd     = inst[9:7];
            rs1    = inst[17:15];
            rs2    = inst[22:20];
            wr_reg = 1'b0;
            t      = T_ALU;
            val    = '0;
            if (inst == '0) begin
                running = 1'b0;
            end else if ((opc == OP_ADDI) && (f3 == 3'd0)) begin
                val    = x[rs1] + {{20{inst[31]}}, inst[31:20]};
                wr_reg = 1'b1;
            end else if (opc == OP_LUI) begin
                val    = {inst[31:12], 12'b0};
                wr_reg = 1'b1;
            end else if (opc == OP_LOAD) begin
                ea  = x[rs1] + {{20{inst[31]}}, inst[31:20]};
                raw = (ea == I2C_ADDRESS) ? i2c_reg : model_mem[ea[10:2]];
                // extension from bit 7 or 15 on the low lanes
                case (f3)
                    3'd0:    val = {{24{raw[7]}}, raw[7:0]};
                    3'd1:    val = {{16{raw[15]}}, raw[15:0]};
                    3'd4:    val = {24'b0, raw[7:0]};
                    3'd5:    val = {16'b0, raw[15:0]};
                    default: val = raw;
                endcase
                if (ea == I2C_ADDRESS) begin
                    t = T_I2C;
                end else begin
                    t = stored[ea[10:2]] ? T_MERGE : T_LOAD;
                end
                wr_reg = 1'b1;
            end else if (opc == OP_STORE) begin
                ea = x[rs1] + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                case (f3)
                    3'd0: begin
                        data = {24'b0, x[rs2][7:0]};
                        mask = 4'b0001;
                    end
                    3'd1: begin
                        data = {16'b0, x[rs2][15:0]};
                        mask = 4'b0011;
                    end
                    default: begin
                        data = x[rs2];
                        mask = 4'b1111;
                    end
                endcase
                if (ea == I2C_ADDRESS) begin
                    i2c_reg = data;
                    t       = T_I2C;
                end else begin
                    t = T_STORE;
                    if (ea < RAM_BYTES) begin
                        stored[ea[10:2]] = 1'b1;
                        for (int b = 0; b < 4; b++) begin
                            if (mask[b]) begin
                                model_mem[ea[10:2]][b*8 +: 8] = data[b*8 +: 8];
                            end
                        end
                    end
                end
                push_event(1'b1, t, ea, data, mask);
            end
            // x0 never takes a write
            if (wr_reg && (rd != 3'd0)) begin
                x[rd] = val;
                push_event(1'b0, t, {29'b0, rd}, val, 4'b0000);
            end
        end
        return n;
    endfunction

    task automatic report_test(input int t);
        $display("test %0d %s: %s, %0d of %0d writes seen, %0d errors", t + 1,
                 test_name[t], (err_count[t] == 0) ? "ok" : "mismatch",
                 seen_count[t], exp_count[t], err_count[t]);
    endtask

    task automatic compare_event(input logic is_mem, input word_t addr,
                                 input word_t data, input logic [3:0] mask);
        exp_event_t ev;
        int         bad;
        bad = 0;
        assert (expected.size() > 0) else begin
            $display("unexpected %s write at %0t, the model has none left",
                     is_mem ? "bus" : "register", $time);
            errors++;
        end
        if (expected.size() > 0) begin
            ev = expected.pop_front();
            assert (ev.is_mem == is_mem) else begin
                $display("%s write at %0t while the model expected a %s write next",
                         is_mem ? "bus" : "register", $time,
                         ev.is_mem ? "bus" : "register");
                bad++;
            end
            if (ev.is_mem == is_mem) begin
                assert (ev.addr == addr) else begin
                    $display("error at %0t: %s expected %h got %h", $time,
                             is_mem ? "mem_wr.addr" : "reg_wr.idx", ev.addr, addr);
                    bad++;
                end
                assert (ev.data == data) else begin
                    $display("error at %0t: %s expected %h got %h", $time,
                             is_mem ? "mem_wr.wdata" : "reg_wr.data", ev.data, data);
                    bad++;
                end
                // byte mask exists on bus writes only
                if (is_mem) begin
                    assert (ev.mask == mask) else begin
                        $display("error at %0t: wmask expected %b got %b", $time,
                                 ev.mask, mask);
                        bad++;
                    end
                end
            end
            errors += bad;
            err_count[ev.test] += bad;
            seen_count[ev.test]++;
            checked++;
            if (seen_count[ev.test] == exp_count[ev.test]) begin
                report_test(ev.test);
            end
        end
    endtask

    // DUT outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!nrst) begin
            prev_write = 1'b0;
        end else begin
            if (reg_wr.we) begin
                reg_writes++;
                assert (reg_wr.idx != 3'd0) else begin
                    $display("register write to x0 at %0t", $time);
                    errors++;
                end
                compare_event(1'b0, {29'b0, reg_wr.idx}, reg_wr.data, 4'b0000);
            end
            // one store per rise of the write level
            // byte mask taken from inside the top
            if (mem_wr.write && !prev_write) begin
                mem_writes++;
                compare_event(1'b1, mem_wr.addr, mem_wr.wdata, dut.wmask);
            end
            prev_write = mem_wr.write;
        end
    end

    initial begin
        nrst       = 1'b0;
        errors     = 0;
        checked    = 0;
        reg_writes = 0;
        mem_writes = 0;
        model_regs = 0;
        model_mems = 0;
        cycles     = 0;
        timed_out  = 1'b0;
        prev_write = 1'b0;
        for (int t = 0; t < N_TESTS; t++) begin
            exp_count[t]  = 0;
            seen_count[t] = 0;
            err_count[t]  = 0;
        end
        test_name[T_ALU]   = "addi/lui writes";
        test_name[T_STORE] = "ram stores";
        test_name[T_LOAD]  = "load extension";
        test_name[T_MERGE] = "store then load";
        test_name[T_I2C]   = "i2c store and load";
        test_name[T_HALT]  = "halt and write count";

        steps = build_expected();
        limit = steps * 20 + 50;
        $display("model: %0d instructions, %0d register writes, %0d bus writes",
                 steps, model_regs, model_mems);

        repeat (2) @(posedge clk);
        #5 nrst = 1'b1;
        @(negedge clk);
        assert (!halted && !reg_wr.we && !mem_wr.read && !mem_wr.write) else begin
            $display("outputs not idle after reset at %0t", $time);
            errors++;
            err_count[T_HALT]++;
        end

        while (!halted && (cycles < limit)) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = !halted;
        if (timed_out) begin
            $display("timeout: halted did not rise within %0d cycles", limit);
            err_count[T_HALT]++;
        end else begin
            // a few idle cycles to catch stray writes after halt
            repeat (4) @(negedge clk);
        end
        // last compare has run by the next rising edge
        @(posedge clk);

        for (int t = 0; t < T_HALT; t++) begin
            if (seen_count[t] != exp_count[t]) begin
                report_test(t);
                errors++;
            end
        end
        assert (expected.size() == 0) else begin
            $display("%0d predicted writes never appeared", expected.size());
            errors++;
            err_count[T_HALT]++;
        end
        assert (reg_writes == model_regs) else begin
            $display("error at %0t: register write count expected %0d got %0d",
                     $time, model_regs, reg_writes);
            errors++;
            err_count[T_HALT]++;
        end
        assert (mem_writes == model_mems) else begin
            $display("error at %0t: bus write count expected %0d got %0d",
                     $time, model_mems, mem_writes);
            errors++;
            err_count[T_HALT]++;
        end
        seen_count[T_HALT] = reg_writes + mem_writes;
        exp_count[T_HALT]  = model_regs + model_mems;
        report_test(T_HALT);

        $display("%0d writes checked, %0d errors, %0d cycles", checked, errors, cycles);
        if ((errors == 0) && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- program.hex
// one 32-bit word per line, instructions from byte address 0
// data area from byte 0x80 (word 0x20), used by the loads and stores
08000093 // addi x1, x0, 0x80
0000a103 // lw   x2, 0(x1)
00008183 // lb   x3, 0(x1)
00009203 // lh   x4, 0(x1)
0000c283 // lbu  x5, 0(x1)
0000d303 // lhu  x6, 0(x1)
00408383 // lb   x7, 4(x1)
00510013 // addi x0, x2, 5
fff00193 // addi x3, x0, -1
00308423 // sb   x3, 8(x1)
0080a203 // lw   x4, 8(x1)
00209623 // sh   x2, 12(x1)
00c0a283 // lw   x5, 12(x1)
0040a823 // sw   x4, 16(x1)
01009303 // lh   x6, 16(x1)
000e23b7 // lui  x7, 0xe2
91338393 // addi x7, x7, -1773
0053a023 // sw   x5, 0(x7)
0003a303 // lw   x6, 0(x7)
00130093 // addi x1, x6, 1
00000000 // halt
00000000
@20
89abcdef
13572468
a5a5a5a5
0f0f0f0f
00000000

//--- vlog.f
mem_pkg.sv
exec_unit.sv
mem_handler.sv
data_ram.sv
i2c_port.sv
soc_top.sv
tb_soc.sv

//--- Bender.yml
package:
  name: soc_ldst

sources:
  - mem_pkg.sv
  - exec_unit.sv
  - mem_handler.sv
  - data_ram.sv
  - i2c_port.sv
  - soc_top.sv
  - target: test
    files:
      - tb_soc.sv

export_include_dirs: []

dependencies: {}
